/* logic/bus_pkg.sv */
package bus_pkg;

    // operation carried on the data port and on every bank port
    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } op_e;

    // tag that routes read data back to the master that asked
    typedef enum logic {
        MST_INST = 1'b0,
        MST_DATA = 1'b1
    } master_e;

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;  // word address, not byte address
    typedef logic [3:0]  mask_t;  // byte enable, bit 0 is bits 7:0

    // instruction port only ever reads
    typedef struct packed {
        addr_t addr;
    } inst_req_t;

    typedef struct packed {
        op_e   op;
        addr_t addr;
        word_t wdata;
        mask_t mask;
    } data_req_t;

    // request as seen by a single bank
    typedef struct packed {
        master_e mst;
        op_e     op;
        addr_t   idx;    // word index inside the bank, upper bits zero
        word_t   wdata;
        mask_t   mask;
    } bank_req_t;

    typedef struct packed {
        logic    valid;
        master_e mst;
        word_t   rdata;
    } bank_rsp_t;

endpackage

/* logic/mem_map_pkg.sv */
package mem_map_pkg;

    // default memory map of the fabric
    //
    // two banks stand in for the base and ext SRAMs of the board,
    // the bank is picked by the top word-address bits, so the
    // address width has to cover NUM_BANKS * BANK_WORDS words

    // base bank plus ext bank
    localparam int NUM_BANKS_DEF = 2;

    // words held by each bank
    localparam int BANK_WORDS_DEF = 64;

    // 1 bank select bit + 6 index bits
    localparam int WORD_ADDR_W_DEF = 7;

endpackage

/* logic/bank_router.sv */
`timescale 1ns/100ps

module bank_router #(
    parameter int NUM_BANKS,
    parameter int WORD_ADDR_W
) (
    input  logic                inst_req_valid_i,
    input  bus_pkg::inst_req_t  inst_req_i,
    input  logic                data_req_valid_i,
    input  bus_pkg::data_req_t  data_req_i,
    output logic                data_req_ready_o,
    output bus_pkg::bank_req_t  bank_req_o [NUM_BANKS],
    output logic [NUM_BANKS-1:0] bank_req_valid_o
);

    import bus_pkg::*;

    localparam int SEL_W = $clog2(NUM_BANKS);
    localparam int IDX_W = WORD_ADDR_W - SEL_W;  // index bits inside one bank

    logic [SEL_W-1:0] inst_bank;
    logic [SEL_W-1:0] data_bank;
    logic             same_bank;

    bank_req_t        inst_bank_req;
    bank_req_t        data_bank_req;

    // bank select is the top of the used word address
    assign inst_bank = inst_req_i.addr[WORD_ADDR_W-1 -: SEL_W];
    assign data_bank = data_req_i.addr[WORD_ADDR_W-1 -: SEL_W];
    assign same_bank = (inst_bank == data_bank);

    // instruction fetch has priority, data waits on a shared bank
    // ready does not look at data valid, so no loop through the master
    assign data_req_ready_o = !(inst_req_valid_i && same_bank);

    // instruction side, always a full word read
    always_comb begin
        inst_bank_req            = '0;
        inst_bank_req.mst        = MST_INST;
        inst_bank_req.op         = OP_READ;
        inst_bank_req.idx[IDX_W-1:0] = inst_req_i.addr[IDX_W-1:0];
        inst_bank_req.mask       = '1;
    end

    // data side keeps op, data and byte mask
    always_comb begin
        data_bank_req            = '0;
        data_bank_req.mst        = MST_DATA;
        data_bank_req.op         = data_req_i.op;
        data_bank_req.idx[IDX_W-1:0] = data_req_i.addr[IDX_W-1:0];
        data_bank_req.wdata      = data_req_i.wdata;
        data_bank_req.mask       = data_req_i.mask;
    end

    // one port per bank
    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank_port
        logic inst_hit;
        logic data_hit;

        assign inst_hit = inst_req_valid_i && (inst_bank == SEL_W'(b));
        // ready low already means inst holds this bank
        assign data_hit = data_req_valid_i && data_req_ready_o
                          && (data_bank == SEL_W'(b));

        assign bank_req_valid_o[b] = inst_hit || data_hit;
        assign bank_req_o[b]       = inst_hit ? inst_bank_req : data_bank_req;
    end

endmodule

/* logic/sram_bank.sv */
`timescale 1ns/100ps

module sram_bank #(
    parameter int BANK_WORDS
) (
    input  logic                clk_50M,
    input  logic                reset_i,
    input  logic                req_valid_i,
    input  bus_pkg::bank_req_t  req_i,
    output bus_pkg::bank_rsp_t  rsp_o
);

    import bus_pkg::*;

    localparam int IDX_W     = $clog2(BANK_WORDS);
    localparam int NUM_BYTES = $bits(mask_t);

    word_t            mem [BANK_WORDS];

    logic [IDX_W-1:0] idx;
    logic             rd_fire;
    logic             wr_fire;

    logic             rsp_valid;
    master_e          rsp_mst;
    word_t            rsp_rdata;

    assign idx     = req_i.idx[IDX_W-1:0];  // router already cleared the bank bits
    assign rd_fire = req_valid_i && (req_i.op == OP_READ);
    assign wr_fire = req_valid_i && (req_i.op == OP_WRITE);

    // byte lanes written only where the mask is set
    always_ff @(posedge clk_50M) begin
        if (wr_fire) begin
            for (int b = 0; b < NUM_BYTES; b++) begin
                if (req_i.mask[b]) begin
                    mem[idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
                end
            end
        end
    end

    // registered read, data and tag held until the next read
    always_ff @(posedge clk_50M) begin
        if (rd_fire) begin
            rsp_rdata <= mem[idx];
            rsp_mst   <= req_i.mst;
        end
    end

    always_ff @(posedge clk_50M) begin
        if (reset_i) begin
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= rd_fire;  // one cycle pulse per read
        end
    end

    assign rsp_o = '{valid: rsp_valid, mst: rsp_mst, rdata: rsp_rdata};

endmodule

/* logic/resp_merge.sv */
`timescale 1ns/100ps

module resp_merge #(
    parameter int NUM_BANKS
) (
    input  bus_pkg::bank_rsp_t bank_rsp_i [NUM_BANKS],
    output logic               inst_rsp_valid_o,
    output bus_pkg::word_t     inst_rdata_o,
    output logic               data_rsp_valid_o,
    output bus_pkg::word_t     data_rdata_o
);

    import bus_pkg::*;

    // at most one bank answers each master per cycle, since the
    // router never hands one master two banks in the same cycle
    always_comb begin
        inst_rsp_valid_o = 1'b0;
        inst_rdata_o     = '0;
        data_rsp_valid_o = 1'b0;
        data_rdata_o     = '0;

        for (int b = 0; b < NUM_BANKS; b++) begin
            if (bank_rsp_i[b].valid) begin
                if (bank_rsp_i[b].mst == MST_INST) begin
                    inst_rsp_valid_o = 1'b1;
                    inst_rdata_o     = bank_rsp_i[b].rdata;
                end else begin
                    data_rsp_valid_o = 1'b1;
                    data_rdata_o     = bank_rsp_i[b].rdata;
                end
            end
        end
    end

endmodule

/* logic/mem_fabric_top.sv */
`timescale 1ns/100ps

module mem_fabric_top #(
    parameter int NUM_BANKS   = mem_map_pkg::NUM_BANKS_DEF,
    parameter int BANK_WORDS  = mem_map_pkg::BANK_WORDS_DEF,
    parameter int WORD_ADDR_W = mem_map_pkg::WORD_ADDR_W_DEF
) (
    input  logic               clk_50M,
    input  logic               reset_i,

    // instruction master, read only, never stalled
    input  logic               inst_req_valid_i,
    input  bus_pkg::inst_req_t inst_req_i,

    // data master, valid/ready
    input  logic               data_req_valid_i,
    input  bus_pkg::data_req_t data_req_i,
    output logic               data_req_ready_o,

    output logic               inst_rsp_valid_o,
    output bus_pkg::word_t     inst_rdata_o,
    output logic               data_rsp_valid_o,
    output bus_pkg::word_t     data_rdata_o
);

    import bus_pkg::*;

    bank_req_t            bank_req [NUM_BANKS];
    logic [NUM_BANKS-1:0] bank_req_valid;
    bank_rsp_t            bank_rsp [NUM_BANKS];

    bank_router #(
        .NUM_BANKS   (NUM_BANKS),
        .WORD_ADDR_W (WORD_ADDR_W)
    ) u_router (
        .inst_req_valid_i (inst_req_valid_i),
        .inst_req_i       (inst_req_i),
        .data_req_valid_i (data_req_valid_i),
        .data_req_i       (data_req_i),
        .data_req_ready_o (data_req_ready_o),
        .bank_req_o       (bank_req),
        .bank_req_valid_o (bank_req_valid)
    );

    // bank 0 is the base SRAM, bank 1 the ext SRAM
    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
        sram_bank #(
            .BANK_WORDS (BANK_WORDS)
        ) u_bank (
            .clk_50M     (clk_50M),
            .reset_i     (reset_i),
            .req_valid_i (bank_req_valid[b]),
            .req_i       (bank_req[b]),
            .rsp_o       (bank_rsp[b])
        );
    end

    resp_merge #(
        .NUM_BANKS (NUM_BANKS)
    ) u_merge (
        .bank_rsp_i       (bank_rsp),
        .inst_rsp_valid_o (inst_rsp_valid_o),
        .inst_rdata_o     (inst_rdata_o),
        .data_rsp_valid_o (data_rsp_valid_o),
        .data_rdata_o     (data_rdata_o)
    );

endmodule

/* tb/fabric_props.sv */
`timescale 1ns/100ps

module fabric_props (
    input logic               clk_i,
    input logic               reset_i,
    input logic               inst_req_valid_i,
    input logic               data_req_valid_i,
    input bus_pkg::data_req_t data_req_i,
    input logic               data_req_ready_i,
    input logic               inst_rsp_valid_i,
    input logic               data_rsp_valid_i
);

    import bus_pkg::*;

    int fail_cnt = 0;  // read by the testbench top at the end

    // no response may follow a reset cycle
    a_rst_quiet: assert property (@(posedge clk_i)
        reset_i |=> (!inst_rsp_valid_i && !data_rsp_valid_i))
        else begin
            fail_cnt++;
            $error("response valid high right after reset");
        end

    a_inst_latency: assert property (@(posedge clk_i) disable iff (reset_i)
        inst_req_valid_i |=> inst_rsp_valid_i)
        else begin
            fail_cnt++;
            $error("instruction read without response one cycle later");
        end

    a_data_latency: assert property (@(posedge clk_i) disable iff (reset_i)
        (data_req_valid_i && data_req_ready_i && data_req_i.op == OP_READ)
        |=> data_rsp_valid_i)
        else begin
            fail_cnt++;
            $error("data read without response one cycle later");
        end

    // master must hold a stalled request
    a_stall_hold: assert property (@(posedge clk_i) disable iff (reset_i)
        (data_req_valid_i && !data_req_ready_i)
        |=> (data_req_valid_i && $stable(data_req_i)))
        else begin
            fail_cnt++;
            $error("stalled data request changed or dropped");
        end

endmodule

/* tb/fabric_checker.sv */
`timescale 1ns/100ps

module fabric_checker #(
    parameter int NUM_BANKS,
    parameter int BANK_WORDS,
    parameter int WORD_ADDR_W
) (
    input logic               clk_i,
    input logic               reset_i,
    input logic               inst_req_valid_i,
    input bus_pkg::inst_req_t inst_req_i,
    input logic               data_req_valid_i,
    input bus_pkg::data_req_t data_req_i,
    input logic               data_req_ready_i,
    input logic               inst_rsp_valid_i,
    input bus_pkg::word_t     inst_rdata_i,
    input logic               data_rsp_valid_i,
    input bus_pkg::word_t     data_rdata_i
);

    import bus_pkg::*;

    localparam int NUM_WORDS = NUM_BANKS * BANK_WORDS;
    localparam int SEL_W     = $clog2(NUM_BANKS);

    word_t model [NUM_WORDS];  // reference memory, flat word array
    word_t inst_q [$];         // reads due on the next edge
    word_t data_q [$];

    logic armed = 1'b0;  // set once reset has been seen
    int   test_num    = 0;
    int   test_checks = 0;
    int   test_errs   = 0;
    int   check_cnt   = 0;
    int   err_cnt     = 0;

    function automatic int word_index(input addr_t a);
        return int'(a[WORD_ADDR_W-1:0]);
    endfunction

    function automatic int bank_of(input addr_t a);
        return int'(a[WORD_ADDR_W-1 -: SEL_W]);
    endfunction

    task automatic note_check(input logic ok);
        test_checks++;
        check_cnt++;
        if (!ok) begin
            test_errs++;
            err_cnt++;
        end
    endtask

    task automatic check_rsp(input string vname, input string dname, input logic exp_v,
                             input word_t exp_d, input logic got_v, input word_t got_d);
        if (got_v !== exp_v) begin
            note_check(1'b0);
            $display("ERR %0t %s expected %b got %b", $time, vname, exp_v, got_v);
        end else if (exp_v && got_d !== exp_d) begin
            note_check(1'b0);
            $display("ERR %0t %s expected %08h got %08h", $time, dname, exp_d, got_d);
        end else begin
            note_check(1'b1);
        end
    endtask

    always @(posedge clk_i) begin
        word_t exp_inst;
        word_t exp_data;
        logic  exp_inst_v;
        logic  exp_data_v;
        logic  exp_ready;
        int    i;

        // outputs seen here belong to requests taken on the previous edge
        if (armed) begin
            exp_inst_v = (inst_q.size() > 0);
            exp_data_v = (data_q.size() > 0);
            exp_inst   = exp_inst_v ? inst_q.pop_front() : '0;
            exp_data   = exp_data_v ? data_q.pop_front() : '0;
            check_rsp("inst_rsp_valid_o", "inst_rdata_o", exp_inst_v, exp_inst,
                      inst_rsp_valid_i, inst_rdata_i);
            check_rsp("data_rsp_valid_o", "data_rdata_o", exp_data_v, exp_data,
                      data_rsp_valid_i, data_rdata_i);
        end

        if (reset_i) begin
            inst_q.delete();
            data_q.delete();
            armed = 1'b1;
        end else if (armed) begin
            // instruction wins a shared bank
            exp_ready = !(inst_req_valid_i
                          && bank_of(inst_req_i.addr) == bank_of(data_req_i.addr));
            if (data_req_ready_i !== exp_ready) begin
                note_check(1'b0);
                $display("ERR %0t data_req_ready_o expected %b got %b",
                         $time, exp_ready, data_req_ready_i);
            end else begin
                note_check(1'b1);
            end

            if (inst_req_valid_i) begin
                inst_q.push_back(model[word_index(inst_req_i.addr)]);
            end

            if (data_req_valid_i && data_req_ready_i) begin
                i = word_index(data_req_i.addr);
                if (data_req_i.op == OP_WRITE) begin
                    for (int b = 0; b < 4; b++) begin
                        if (data_req_i.mask[b]) begin
                            model[i][8*b +: 8] = data_req_i.wdata[8*b +: 8];
                        end
                    end
                end else begin
                    data_q.push_back(model[i]);
                end
            end
        end
    end

    task automatic end_test(input string name);
        test_num++;
        $display("test %0d %s: %0d checks, %0d errors", test_num, name,
                 test_checks, test_errs);
        test_checks = 0;
        test_errs   = 0;
    endtask

    task automatic final_report();
        $display("summary: %0d tests, %0d checks, %0d errors", test_num, check_cnt, err_cnt);
    endtask

endmodule

/* tb/fabric_tb.sv */
`timescale 1ns/100ps

module fabric_tb;

    import bus_pkg::*;
    import mem_map_pkg::*;

    localparam int CLK_NS    = 8;
    localparam int NUM_WORDS = NUM_BANKS_DEF * BANK_WORDS_DEF;
    localparam int IDX_W     = $clog2(BANK_WORDS_DEF);
    localparam int SEL_W     = $clog2(NUM_BANKS_DEF);
    localparam int N_RAND    = 64;
    localparam int N_COLL    = 12;
    localparam int N_PAIR    = 24;

    // worst case per test, collisions stall up to 4 extra cycles
    localparam int TEST_CYCLES = 3 + 2 * NUM_WORDS + 2 * N_RAND + 5 * N_COLL + N_PAIR
                                 + 6 * 4;
    localparam int TIMEOUT_NS  = (TEST_CYCLES + 200) * CLK_NS;

    logic      clk_50M = 1'b0;
    logic      reset;
    logic      inst_req_valid;
    inst_req_t inst_req;
    logic      data_req_valid;
    data_req_t data_req;
    logic      data_req_ready;
    logic      inst_rsp_valid;
    word_t     inst_rdata;
    logic      data_rsp_valid;
    word_t     data_rdata;

    logic [31:0] lfsr_state = 32'h1d58;

    always #(CLK_NS / 2) clk_50M = ~clk_50M;

    mem_fabric_top #(
        .NUM_BANKS   (NUM_BANKS_DEF),
        .BANK_WORDS  (BANK_WORDS_DEF),
        .WORD_ADDR_W (WORD_ADDR_W_DEF)
    ) u_mem_fabric_top (
        .clk_50M          (clk_50M),
        .reset_i          (reset),
        .inst_req_valid_i (inst_req_valid),
        .inst_req_i       (inst_req),
        .data_req_valid_i (data_req_valid),
        .data_req_i       (data_req),
        .data_req_ready_o (data_req_ready),
        .inst_rsp_valid_o (inst_rsp_valid),
        .inst_rdata_o     (inst_rdata),
        .data_rsp_valid_o (data_rsp_valid),
        .data_rdata_o     (data_rdata)
    );

    fabric_checker #(
        .NUM_BANKS   (NUM_BANKS_DEF),
        .BANK_WORDS  (BANK_WORDS_DEF),
        .WORD_ADDR_W (WORD_ADDR_W_DEF)
    ) u_checker (
        .clk_i            (clk_50M),
        .reset_i          (reset),
        .inst_req_valid_i (inst_req_valid),
        .inst_req_i       (inst_req),
        .data_req_valid_i (data_req_valid),
        .data_req_i       (data_req),
        .data_req_ready_i (data_req_ready),
        .inst_rsp_valid_i (inst_rsp_valid),
        .inst_rdata_i     (inst_rdata),
        .data_rsp_valid_i (data_rsp_valid),
        .data_rdata_i     (data_rdata)
    );

    bind mem_fabric_top fabric_props u_props (
        .clk_i            (clk_50M),
        .reset_i          (reset_i),
        .inst_req_valid_i (inst_req_valid_i),
        .data_req_valid_i (data_req_valid_i),
        .data_req_i       (data_req_i),
        .data_req_ready_i (data_req_ready_o),
        .inst_rsp_valid_i (inst_rsp_valid_o),
        .data_rsp_valid_i (data_rsp_valid_o)
    );

    // fibonacci lfsr, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            r          = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic addr_t addr_in_bank(input int bank);
        return addr_t'(bank * BANK_WORDS_DEF) + rand_bits(IDX_W);
    endfunction

    function automatic data_req_t make_data(input op_e op, input addr_t a, input word_t wd,
                                            input mask_t m);
        data_req_t d;
        d.op    = op;
        d.addr  = a;
        d.wdata = wd;
        d.mask  = m;
        return d;
    endfunction

    function automatic op_e random_op();
        logic [31:0] r;
        r = rand_bits(1);
        return r[0] ? OP_WRITE : OP_READ;
    endfunction

    // call right after a rising edge, returns once the data side is taken
    task automatic drive(input logic iv, input addr_t ia, input logic dv,
                         input data_req_t dr, input int inst_hold);
        int held;
        held = 0;
        inst_req_valid <= iv;
        inst_req       <= '{addr: ia};
        data_req_valid <= dv;
        data_req       <= dr;
        @(posedge clk_50M);
        while (dv && data_req_ready !== 1'b1) begin
            held++;
            if (held > inst_hold) begin
                inst_req_valid <= 1'b0;  // fetch steps aside
            end
            @(posedge clk_50M);
        end
    endtask

    task automatic close_test(input string name);
        inst_req_valid <= 1'b0;
        data_req_valid <= 1'b0;
        repeat (2) @(posedge clk_50M);
        @(negedge clk_50M);
        u_checker.end_test(name);
        @(posedge clk_50M);
    endtask

    initial begin
        #(TIMEOUT_NS);
        $display("watchdog expired after %0d ns, tests did not finish", TIMEOUT_NS);
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin
        int    order [NUM_WORDS];
        int    j;
        int    tmp;
        int    bank;
        addr_t da;

        reset          <= 1'b1;
        inst_req_valid <= 1'b0;
        inst_req       <= '0;
        data_req_valid <= 1'b0;
        data_req       <= '0;
        repeat (3) @(posedge clk_50M);
        reset <= 1'b0;
        close_test("reset valids low");

        // every word written once, then read back shuffled
        for (int a = 0; a < NUM_WORDS; a++) begin
            drive(1'b0, '0, 1'b1, make_data(OP_WRITE, addr_t'(a), rand_bits(32), 4'hf), 0);
            order[a] = a;
        end
        for (int i = NUM_WORDS - 1; i > 0; i--) begin
            j        = int'(rand_bits(8) % (i + 1));
            tmp      = order[i];
            order[i] = order[j];
            order[j] = tmp;
        end
        for (int i = 0; i < NUM_WORDS; i++) begin
            drive(1'b0, '0, 1'b1, make_data(OP_READ, addr_t'(order[i]), '0, '0), 0);
        end
        close_test("fill and shuffled readback");

        for (int n = 0; n < N_RAND; n++) begin
            da = rand_bits(WORD_ADDR_W_DEF);
            drive(1'b0, '0, 1'b1,
                  make_data(random_op(), da, rand_bits(32), mask_t'(rand_bits(4))), 0);
        end
        close_test("partial mask writes");

        for (int n = 0; n < N_RAND; n++) begin
            drive(1'b1, rand_bits(WORD_ADDR_W_DEF), 1'b0, '0, 0);
        end
        close_test("instruction reads");

        for (int n = 0; n < N_COLL; n++) begin
            bank = int'(rand_bits(SEL_W) % NUM_BANKS_DEF);
            drive(1'b1, addr_in_bank(bank), 1'b1,
                  make_data(random_op(), addr_in_bank(bank), rand_bits(32),
                            mask_t'(rand_bits(4))),
                  int'(rand_bits(2)));
        end
        close_test("same bank collision");

        for (int n = 0; n < N_PAIR; n++) begin
            bank = int'(rand_bits(SEL_W) % NUM_BANKS_DEF);
            da   = addr_in_bank((bank + 1) % NUM_BANKS_DEF);
            drive(1'b1, addr_in_bank(bank), 1'b1,
                  make_data(random_op(), da, rand_bits(32), mask_t'(rand_bits(4))), 0);
        end
        close_test("different banks in parallel");

        u_checker.final_report();
        if (u_checker.err_cnt == 0 && u_mem_fabric_top.u_props.fail_cnt == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

/* project.f */
logic/bus_pkg.sv
logic/mem_map_pkg.sv
logic/bank_router.sv
logic/sram_bank.sv
logic/resp_merge.sv
logic/mem_fabric_top.sv
tb/fabric_props.sv
tb/fabric_checker.sv
tb/fabric_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the fabric testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal \
    -f project.f \
    --top-module fabric_tb \
    -o Vfabric_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/Vfabric_tb)
sim_status=$?
echo "$sim_out"

if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "NO ERRORS" <<< "$sim_out"; then
    exit 0
fi

echo "simulation did not report a clean run"
exit 1
